// ==== mem_map.sv ====
// mem_map: transaction state, block/page map table and module request dispatch
`timescale 1ns/1ps
`default_nettype none

module mem_map(
	input logic clk_sys,
	input logic reset,
	input logic dw,
	input logic dr,
	input logic ds,
	input logic [0:mera_mem_pkg::nb_w-1] nb,
	input mera_mem_pkg::bus_addr_u ad,
	input mera_mem_pkg::bus_word_t ddt,
	output logic [mera_mem_pkg::mod_count-1:0] req_sel,
	output logic req_we,
	output logic [0:mera_mem_pkg::frame_w-1] req_frame,
	output logic [0:mera_mem_pkg::offset_w-1] req_offset,
	output mera_mem_pkg::bus_word_t req_wdata,
	output logic set_ok,
	output logic txn_open
);

	// map table, indexed by {nb, page}
	mera_mem_pkg::map_entry_t map_tab [0:mera_mem_pkg::map_depth-1];
	mera_mem_pkg::map_entry_t lut;
	mera_mem_pkg::map_entry_t set_entry;
	logic [0:mera_mem_pkg::nb_w+mera_mem_pkg::page_w-1] rd_idx;
	logic [0:mera_mem_pkg::nb_w+mera_mem_pkg::page_w-1] set_idx;
	logic strobe;
	logic start;

	// ------------------------------------------------------------
	// transaction start
	// ------------------------------------------------------------

	assign strobe = dw | dr | ds;
	// new request only when nothing is in flight
	assign start = strobe & ~txn_open;

	// lookup for dw/dr
	assign rd_idx = {nb, ad.mem.page};
	assign lut = map_tab[rd_idx];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			txn_open <= 1'b0;
			set_ok <= 1'b0;
			req_sel <= '0;
		end else begin
			// open on first strobe, close on first edge without one
			txn_open <= strobe;
			set_ok <= start & ds;
			req_sel <= '0;
			// unmapped page: no select, master times out
			if (start && (dw || dr) && lut.valid) begin
				req_sel[lut.mod] <= 1'b1;
			end
		end
	end

	// request payload, latched with the start
	always_ff @(posedge clk_sys) begin
		if (start) begin
			req_we <= dw;
			req_frame <= lut.frame;
			req_offset <= ad.mem.offset;
			req_wdata <= ddt;
			// ds fields for the map write one edge later
			set_idx <= {nb, ad.cfg.page};
			set_entry.valid <= ad.cfg.valid;
			set_entry.mod <= ad.cfg.mod;
			set_entry.frame <= ad.cfg.frame;
		end
	end

	// ------------------------------------------------------------
	// map table write
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			// all entries invalid after reset
			for (int i = 0; i < mera_mem_pkg::map_depth; i++) begin
				map_tab[i].valid <= 1'b0;
			end
		end else if (set_ok) begin
			map_tab[set_idx] <= set_entry;
		end
	end

	// one select per transaction, a single cycle long
	a_sel_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		(|req_sel) |=> (req_sel == '0));

	// master drives one strobe at a time
	a_one_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({dw, dr, ds}));

endmodule

`default_nettype wire

// ==== mem_module.sv ====
// mem_module: one 16k-word memory module, registered read, one-cycle ok
`timescale 1ns/1ps
`default_nettype none

module mem_module(
	input logic clk_sys,
	input logic reset,
	input logic sel,
	input logic we,
	input logic [0:mera_mem_pkg::frame_w-1] frame,
	input logic [0:mera_mem_pkg::offset_w-1] offset,
	input mera_mem_pkg::bus_word_t wdata,
	output logic ok,
	output mera_mem_pkg::bus_word_t rdata
);

	// 4 frames x 4k words
	mera_mem_pkg::bus_word_t ram [0:(1 << (mera_mem_pkg::frame_w + mera_mem_pkg::offset_w)) - 1];
	logic [0:mera_mem_pkg::frame_w+mera_mem_pkg::offset_w-1] addr;

	// frame selects the 4k block inside the module
	assign addr = {frame, offset};

	// ------------------------------------------------------------
	// ok pulse
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ok <= 1'b0;
		end else begin
			// one cycle after each select
			ok <= sel;
		end
	end

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (sel) begin
			if (we) begin
				ram[addr] <= wdata;
				// write answers with zero data
				rdata <= '0;
			end else begin
				rdata <= ram[addr];
			end
		end
	end

	// ok sits in the cycle after sel, never beside a new select
	a_ok_after_sel: assert property (@(posedge clk_sys) disable iff (reset)
		ok |-> !sel);

endmodule

`default_nettype wire

// ==== mem_resp.sv ====
// mem_resp: merges module and map answers, holds rok and rdt for the transaction
`timescale 1ns/1ps
`default_nettype none

module mem_resp(
	input logic clk_sys,
	input logic reset,
	input logic [mera_mem_pkg::mod_count-1:0] mod_ok,
	input mera_mem_pkg::bus_word_t mod_rdata [0:mera_mem_pkg::mod_count-1],
	input logic set_ok,
	input logic txn_open,
	output logic rok,
	output mera_mem_pkg::bus_word_t rdt
);

	mera_mem_pkg::bus_word_t ok_data;
	// set_ok delayed to line up with mod_ok
	logic set_d;

	// ------------------------------------------------------------
	// answer mux
	// ------------------------------------------------------------

	// at most one module answers, OR the gated words
	always_comb begin
		ok_data = '0;
		for (int i = 0; i < mera_mem_pkg::mod_count; i++) begin
			if (mod_ok[i]) begin
				ok_data = ok_data | mod_rdata[i];
			end
		end
	end

	// ------------------------------------------------------------
	// rok/rdt hold
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			set_d <= 1'b0;
			rok <= 1'b0;
			rdt <= '0;
		end else begin
			set_d <= set_ok;
			if (!txn_open) begin
				// strobe released, drop the answer
				rok <= 1'b0;
				rdt <= '0;
			end else if ((|mod_ok) || set_d) begin
				// ds answers with zero data, ok_data is zero then
				rok <= 1'b1;
				rdt <= ok_data;
			end
		end
	end

	// single answer source per cycle
	a_one_source: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({mod_ok, set_d}));

endmodule

`default_nettype wire

// ==== mera_mem.sv ====
// mera_mem: memory subsystem top, map front end, four modules and response collector
`timescale 1ns/1ps
`default_nettype none

module mera_mem(
	input logic clk_sys,
	input logic reset,
	// system bus strobes
	input logic dw,
	input logic dr,
	input logic ds,
	// block, address, data from the master
	input logic [0:mera_mem_pkg::nb_w-1] nb,
	input mera_mem_pkg::bus_word_t ad,
	input mera_mem_pkg::bus_word_t ddt,
	// answer to the master
	output logic rok,
	output mera_mem_pkg::bus_word_t rdt
);

	// request side
	logic [mera_mem_pkg::mod_count-1:0] req_sel;
	logic req_we;
	logic [0:mera_mem_pkg::frame_w-1] req_frame;
	logic [0:mera_mem_pkg::offset_w-1] req_offset;
	mera_mem_pkg::bus_word_t req_wdata;
	logic set_ok;
	logic txn_open;
	// answer side
	logic [mera_mem_pkg::mod_count-1:0] mod_ok;
	mera_mem_pkg::bus_word_t mod_rdata [0:mera_mem_pkg::mod_count-1];

	// ------------------------------------------------------------
	// front end
	// ------------------------------------------------------------

	mem_map map0(
		.clk_sys(clk_sys),
		.reset(reset),
		.dw(dw),
		.dr(dr),
		.ds(ds),
		.nb(nb),
		.ad(ad),
		.ddt(ddt),
		.req_sel(req_sel),
		.req_we(req_we),
		.req_frame(req_frame),
		.req_offset(req_offset),
		.req_wdata(req_wdata),
		.set_ok(set_ok),
		.txn_open(txn_open)
	);

	// ------------------------------------------------------------
	// memory modules
	// ------------------------------------------------------------

	// shared request bus, one select per module
	for (genvar i = 0; i < mera_mem_pkg::mod_count; i++) begin : gen_mod
		mem_module mod0(
			.clk_sys(clk_sys),
			.reset(reset),
			.sel(req_sel[i]),
			.we(req_we),
			.frame(req_frame),
			.offset(req_offset),
			.wdata(req_wdata),
			.ok(mod_ok[i]),
			.rdata(mod_rdata[i])
		);
	end

	// ------------------------------------------------------------
	// response
	// ------------------------------------------------------------

	mem_resp resp0(
		.clk_sys(clk_sys),
		.reset(reset),
		.mod_ok(mod_ok),
		.mod_rdata(mod_rdata),
		.set_ok(set_ok),
		.txn_open(txn_open),
		.rok(rok),
		.rdt(rdt)
	);

endmodule

`default_nettype wire

// ==== mera_mem_pkg.sv ====
// bus widths, memory geometry, bus address union and map entry type
`default_nettype none

package mera_mem_pkg;

	// ------------------------------------------------------------
	// bus widths
	// ------------------------------------------------------------

	// data and address word
	localparam int word_w = 16;
	// block number (nb)
	localparam int nb_w = 4;

	// ------------------------------------------------------------
	// memory geometry
	// ------------------------------------------------------------

	// four 16k-word modules
	localparam int mod_count = 4;
	localparam int mod_w = 2;
	// four 4k frames per module
	localparam int frame_w = 2;
	localparam int offset_w = 12;
	// page field of ad
	localparam int page_w = 4;
	// one map entry per block and page
	localparam int map_depth = 256;

	// bus word, MSB is bit 0
	typedef logic [0:word_w-1] bus_word_t;

	// ad as seen by dw/dr
	typedef struct packed {
		logic [0:page_w-1] page;
		logic [0:offset_w-1] offset;
	} ad_mem_t;

	// ad as seen by ds (map configuration)
	typedef struct packed {
		logic [0:page_w-1] page;
		logic [0:mod_w-1] mod;
		logic [0:frame_w-1] frame;
		logic valid;
		logic [0:6] unused;
	} ad_cfg_t;

	// same ad word, decoded per strobe
	typedef union packed {
		ad_mem_t mem;
		ad_cfg_t cfg;
	} bus_addr_u;

	// one map table entry
	typedef struct packed {
		logic valid;
		logic [0:mod_w-1] mod;
		logic [0:frame_w-1] frame;
	} map_entry_t;

endpackage

`default_nettype wire

// ==== sources.f ====
mera_mem_pkg.sv
mem_map.sv
mem_module.sv
mem_resp.sv
mera_mem.sv
+incdir+.
tb_mera_mem.sv

// ==== tb_mera_mem_vectors.svh ====
// directed stimulus table with expected rdt, and the task that loads it
// columns {op, nb, ad, ddt, exp}; ad is page/offset for dw and dr
// and page/module/frame/valid for ds
localparam int vec_count = 14;
vec_t vec_tab [0:vec_count-1];

task automatic load_vectors;
	vec_tab[0] = {op_nak, 4'h0, 16'h1234, 16'h0000, 16'h0000};
	vec_tab[1] = {op_set, 4'h2, 16'h1B80, 16'h0000, 16'h0000};
	vec_tab[2] = {op_write, 4'h2, 16'h1055, 16'hBEEF, 16'h0000};
	vec_tab[3] = {op_read, 4'h2, 16'h1055, 16'h0000, 16'hBEEF};
	vec_tab[4] = {op_set, 4'h5, 16'h7480, 16'h0000, 16'h0000};
	vec_tab[5] = {op_write, 4'h5, 16'h7055, 16'h1357, 16'h0000};
	vec_tab[6] = {op_read, 4'h2, 16'h1055, 16'h0000, 16'hBEEF};
	vec_tab[7] = {op_read, 4'h5, 16'h7055, 16'h0000, 16'h1357};
	// remap onto module 2 frame 3, shared with block 2 page 1
	vec_tab[8] = {op_set, 4'h5, 16'h7B80, 16'h0000, 16'h0000};
	vec_tab[9] = {op_read, 4'h5, 16'h7055, 16'h0000, 16'hBEEF};
	vec_tab[10] = {op_set, 4'h5, 16'h7480, 16'h0000, 16'h0000};
	vec_tab[11] = {op_read, 4'h5, 16'h7055, 16'h0000, 16'h1357};
	// invalidate block 2 page 1
	vec_tab[12] = {op_set, 4'h2, 16'h1B00, 16'h0000, 16'h0000};
	vec_tab[13] = {op_nak, 4'h2, 16'h1055, 16'h0000, 16'h0000};
endtask

// ==== tb_mera_mem.sv ====
// testbench for mera_mem: clock, reset, bus tasks, lcg, reference model, compare tasks, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_mera_mem;

	// table op codes
	localparam logic [3:0] op_set = 4'h0;
	localparam logic [3:0] op_write = 4'h1;
	localparam logic [3:0] op_read = 4'h2;
	localparam logic [3:0] op_nak = 4'h3;
	localparam int rand_count = 200;

	typedef struct packed {
		logic [3:0] op;
		logic [0:3] nb;
		mera_mem_pkg::bus_word_t ad;
		mera_mem_pkg::bus_word_t ddt;
		mera_mem_pkg::bus_word_t exp;
	} vec_t;

	`include "tb_mera_mem_vectors.svh"

	// table, random phase, block 9 setup and reset, 40 cycles each
	localparam int watchdog_cycles = (vec_count + rand_count + 16) * 40;

	logic clk_sys;
	logic reset;
	logic dw;
	logic dr;
	logic ds;
	logic [0:mera_mem_pkg::nb_w-1] nb;
	mera_mem_pkg::bus_word_t ad;
	mera_mem_pkg::bus_word_t ddt;
	logic rok;
	mera_mem_pkg::bus_word_t rdt;

	// reference map and memory, memory indexed {module, frame, offset}
	mera_mem_pkg::map_entry_t ref_map [0:mera_mem_pkg::map_depth-1];
	mera_mem_pkg::bus_word_t ref_mem [0:65535];
	mera_mem_pkg::bus_word_t written_q [$];
	logic [31:0] rnd;

	mera_mem dut0(
		.clk_sys(clk_sys),
		.reset(reset),
		.dw(dw),
		.dr(dr),
		.ds(ds),
		.nb(nb),
		.ad(ad),
		.ddt(ddt),
		.rok(rok),
		.rdt(rdt)
	);

	// 8 ns period
	always #4 clk_sys = ~clk_sys;

	// ------------------------------------------------------------
	// failure reporting and compares
	// ------------------------------------------------------------

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1, "testbench stopped at first error");
	endtask

	task automatic check_word(input string name, input mera_mem_pkg::bus_word_t got,
			input mera_mem_pkg::bus_word_t exp);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_latency(input string name, input int got, input int exp);
		if (got != exp) begin
			abort_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	// multiplier and increment of the classic C library lcg
	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// word the reference memory holds behind blk and mem-view addr
	function automatic logic [15:0] mem_index(input logic [0:3] blk,
			input mera_mem_pkg::bus_word_t addr);
		mera_mem_pkg::map_entry_t e;
		e = ref_map[{blk, addr[0:3]}];
		return {e.mod, e.frame, addr[4:15]};
	endfunction

	// ------------------------------------------------------------
	// bus handshake
	// ------------------------------------------------------------

	// one strobe, measured in edges from the sampling edge
	task automatic strobe_cycle(input logic sw, input logic sr, input logic ss,
			input logic [0:3] blk, input mera_mem_pkg::bus_word_t addr,
			input mera_mem_pkg::bus_word_t data, output mera_mem_pkg::bus_word_t got);
		int rise;
		int fall;
		@(posedge clk_sys);
		#1;
		nb = blk;
		ad = addr;
		ddt = data;
		dw = sw;
		dr = sr;
		ds = ss;
		rise = 0;
		while (rok !== 1'b1 && rise < 16) begin
			@(posedge clk_sys);
			#1;
			rise++;
		end
		if (rok !== 1'b1) begin
			abort_run($sformatf("no rok for nb %h ad %h within 16 cycles", blk, addr));
		end
		check_latency("rok rise", rise, 3);
		got = rdt;
		dw = 1'b0;
		dr = 1'b0;
		ds = 1'b0;
		// txn_open closes first, rok drops the edge after
		fall = 0;
		while (rok !== 1'b0 && fall < 16) begin
			@(posedge clk_sys);
			#1;
			fall++;
		end
		if (rok !== 1'b0) begin
			abort_run("rok still high 16 cycles after the strobe was released");
		end
		check_latency("rok fall", fall, 2);
	endtask

	task automatic bus_read(input logic [0:3] blk, input mera_mem_pkg::bus_word_t addr,
			output mera_mem_pkg::bus_word_t got);
		strobe_cycle(1'b0, 1'b1, 1'b0, blk, addr, 16'h0000, got);
	endtask

	task automatic bus_write(input logic [0:3] blk, input mera_mem_pkg::bus_word_t addr,
			input mera_mem_pkg::bus_word_t data, output mera_mem_pkg::bus_word_t got);
		strobe_cycle(1'b1, 1'b0, 1'b0, blk, addr, data, got);
	endtask

	task automatic bus_set(input logic [0:3] blk, input mera_mem_pkg::bus_word_t addr,
			output mera_mem_pkg::bus_word_t got);
		strobe_cycle(1'b0, 1'b0, 1'b1, blk, addr, 16'h0000, got);
	endtask

	// unmapped dr, rok must stay low while held and after release
	task automatic read_unmapped(input logic [0:3] blk, input mera_mem_pkg::bus_word_t addr);
		@(posedge clk_sys);
		#1;
		nb = blk;
		ad = addr;
		dr = 1'b1;
		repeat (16) begin
			@(posedge clk_sys);
			#1;
			if (rok !== 1'b0) begin
				abort_run($sformatf("unexpected rok for unmapped nb %h ad %h", blk, addr));
			end
		end
		dr = 1'b0;
		repeat (3) begin
			@(posedge clk_sys);
			#1;
			if (rok !== 1'b0) begin
				abort_run("unexpected rok after unmapped read was released");
			end
		end
	endtask

	// ------------------------------------------------------------
	// operations with reference model update
	// ------------------------------------------------------------

	// cfg view: page 0-3, module 4-5, frame 6-7, valid 8
	task automatic apply_set(input logic [0:3] blk, input mera_mem_pkg::bus_word_t addr);
		mera_mem_pkg::bus_word_t got;
		bus_set(blk, addr, got);
		check_word("rdt", got, 16'h0000);
		ref_map[{blk, addr[0:3]}] = {addr[8], addr[4:5], addr[6:7]};
	endtask

	task automatic apply_write(input logic [0:3] blk, input mera_mem_pkg::bus_word_t addr,
			input mera_mem_pkg::bus_word_t data);
		mera_mem_pkg::bus_word_t got;
		bus_write(blk, addr, data, got);
		check_word("rdt", got, 16'h0000);
		ref_mem[mem_index(blk, addr)] = data;
	endtask

	task automatic apply_read(input logic [0:3] blk, input mera_mem_pkg::bus_word_t addr,
			output mera_mem_pkg::bus_word_t got);
		bus_read(blk, addr, got);
		check_word("rdt", got, ref_mem[mem_index(blk, addr)]);
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------

	initial begin
		vec_t v;
		mera_mem_pkg::bus_word_t got;
		mera_mem_pkg::bus_word_t addr;
		clk_sys = 1'b0;
		reset = 1'b1;
		dw = 1'b0;
		dr = 1'b0;
		ds = 1'b0;
		nb = '0;
		ad = '0;
		ddt = '0;
		for (int i = 0; i < mera_mem_pkg::map_depth; i++) begin
			ref_map[i] = '0;
		end
		load_vectors();
		repeat (8) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		if (rok !== 1'b0) begin
			abort_run("rok not low after reset");
		end
		check_word("rdt", rdt, 16'h0000);

		// directed table
		for (int i = 0; i < vec_count; i++) begin
			v = vec_tab[i];
			case (v.op)
				op_set: apply_set(v.nb, v.ad);
				op_write: apply_write(v.nb, v.ad, v.ddt);
				op_read: begin
					apply_read(v.nb, v.ad, got);
					check_word("rdt vs table", got, v.exp);
				end
				default: read_unmapped(v.nb, v.ad);
			endcase
		end

		// block 9, page p on module p, frame 3-p
		for (int p = 0; p < 4; p++) begin
			apply_set(4'h9, {p[3:0], p[1:0], ~p[1:0], 1'b1, 7'h00});
		end

		// random writes, reads only of written words
		rnd = 32'd31;
		for (int n = 0; n < rand_count; n++) begin
			rnd = lcg_step(rnd);
			if (written_q.size() == 0 || rnd[31]) begin
				addr = {2'b00, rnd[17:16], rnd[29:18]};
				rnd = lcg_step(rnd);
				apply_write(4'h9, addr, rnd[31:16]);
				written_q.push_back(addr);
			end else begin
				addr = written_q[rnd[30:16] % written_q.size()];
				apply_read(4'h9, addr, got);
			end
		end

		$display("** PASS **");
		$finish;
	end

	// watchdog
	initial begin
		repeat (watchdog_cycles) @(posedge clk_sys);
		abort_run($sformatf("watchdog expired after %0d cycles", watchdog_cycles));
	end

endmodule

`default_nettype wire
